/* rtl/cia_pkg.sv */
package cia_pkg;

  // register map, one 4-bit address per register
  localparam logic [3:0] addr_pra     = 4'h0;
  localparam logic [3:0] addr_prb     = 4'h1;
  localparam logic [3:0] addr_ddra    = 4'h2;
  localparam logic [3:0] addr_ddrb    = 4'h3;
  localparam logic [3:0] addr_talo    = 4'h4;
  localparam logic [3:0] addr_tahi    = 4'h5;
  localparam logic [3:0] addr_tblo    = 4'h6;
  localparam logic [3:0] addr_tbhi    = 4'h7;
  localparam logic [3:0] addr_tod_lo  = 4'h8;
  localparam logic [3:0] addr_tod_mid = 4'h9;
  localparam logic [3:0] addr_tod_hi  = 4'ha;
  // 0xb is not decoded and reads as zero
  localparam logic [3:0] addr_sdr     = 4'hc;
  localparam logic [3:0] addr_icr     = 4'hd;
  localparam logic [3:0] addr_cra     = 4'he;
  localparam logic [3:0] addr_crb     = 4'hf;

  // control register bits, shared by cra and crb
  localparam int cr_start   = 0;
  localparam int cr_oneshot = 3;
  localparam int cr_load    = 4;
  localparam int cra_spmode = 6;
  localparam int crb_inmode = 5;
  localparam int crb_alarm  = 7;

  // interrupt sources and the summary bit
  localparam int icr_ta    = 0;
  localparam int icr_tb    = 1;
  localparam int icr_alrm  = 2;
  localparam int icr_sp    = 3;
  localparam int icr_ir    = 7;
  localparam int icr_src_w = 4;

  // same byte, decoded as a mask write or built as a status read
  typedef union packed {
    struct packed {
      logic                        set_clr;
      logic [icr_ir-icr_src_w-1:0] unused;
      logic [icr_src_w-1:0]        mask;
    } wr;
    struct packed {
      logic                        ir;
      logic [icr_ir-icr_src_w-1:0] unused;
      logic [icr_src_w-1:0]        flags;
    } rd;
  } icr_word_u;

endpackage

/* rtl/cia_ports_sdr.sv */
`timescale 1ns/1ps

module cia_ports_sdr (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] dat_w,
  input  logic       wr_pra,
  input  logic       wr_prb,
  input  logic       wr_ddra,
  input  logic       wr_ddrb,
  input  logic       wr_sdr,
  input  logic       rd_sdr,
  input  logic       spmode,
  input  logic       ta_ovf,
  input  logic       key_valid,
  input  logic [7:0] key_code,
  input  logic [7:0] pa_in,
  output logic [7:0] pa_out,
  output logic [7:0] pb_out,
  output logic [7:0] pra_q,
  output logic [7:0] prb_q,
  output logic [7:0] ddra_q,
  output logic [7:0] ddrb_q,
  output logic [7:0] sdr_q,
  output logic       keyack,
  output logic       sp_event
);

  logic [7:0] pra;
  logic [7:0] prb;
  logic [7:0] ddra;
  logic [7:0] ddrb;
  logic [7:0] pa_in_q;
  logic [7:0] sdr;
  logic       ser_run;
  logic [3:0] ser_cnt;
  logic       ser_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      pra  <= 8'h00;
      prb  <= 8'h00;
      ddra <= 8'h00;
      ddrb <= 8'h00;
    end else begin
      if (wr_pra)
        pra <= dat_w;
      if (wr_prb)
        prb <= dat_w;
      if (wr_ddra)
        ddra <= dat_w;
      if (wr_ddrb)
        ddrb <= dat_w;
    end
  end

  // input pins sampled once before they reach the read path
  always_ff @(posedge clk) begin
    pa_in_q <= pa_in;
  end

  // pins float high unless driven as outputs
  assign pa_out = ~ddra | pra;
  assign pb_out = ~ddrb | prb;

  assign pra_q  = (ddra & pa_out) | (~ddra & pa_in_q);
  assign prb_q  = pb_out;
  assign ddra_q = ddra;
  assign ddrb_q = ddrb;

  // keyboard delivers the code rotated one step and inverted
  always_ff @(posedge clk) begin
    if (reset) begin
      sdr <= 8'h00;
    end else if (key_valid) begin
      sdr <= ~{key_code[6:0], key_code[7]};
    end else if (wr_sdr) begin
      sdr <= dat_w;
    end
  end

  assign sdr_q  = sdr;
  assign keyack = rd_sdr;

  // serial output, one bit per timer A underflow
  always_ff @(posedge clk) begin
    if (reset || !spmode) begin
      ser_run <= 1'b0;
    end else if (wr_sdr) begin
      ser_run <= 1'b1;
    end else if (ser_done) begin
      ser_run <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !ser_run) begin
      ser_cnt <= 4'd0;
    end else if (ta_ovf) begin
      ser_cnt <= ser_cnt + 4'd1;
    end
  end

  // sixteenth underflow shifts out the last bit
  assign ser_done = ser_run & (&ser_cnt) & ta_ovf;
  assign sp_event = key_valid | ser_done;

endmodule

/* rtl/cia_timer_a.sv */
`timescale 1ns/1ps

module cia_timer_a import cia_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        eclk,
  input  logic [7:0]  dat_w,
  input  logic        wr_lo,
  input  logic        wr_hi,
  input  logic        wr_cr,
  output logic [15:0] cnt_q,
  output logic [7:0]  cr_q,
  output logic        spmode,
  output logic        ta_ovf
);

  logic [15:0] latch;
  logic [15:0] cnt;
  logic [7:0]  cr;
  logic        count_en;

  assign count_en = eclk & cr[cr_start];
  assign ta_ovf   = count_en & (cnt == 16'h0000);

  always_ff @(posedge clk) begin
    if (reset) begin
      latch <= 16'hffff;
      cnt   <= 16'hffff;
      cr    <= 8'h00;
    end else begin
      if (count_en) begin
        if (cnt == 16'h0000) begin
          cnt <= latch;
          if (cr[cr_oneshot])
            cr[cr_start] <= 1'b0;
        end else begin
          cnt <= cnt - 16'd1;
        end
      end
      if (wr_lo)
        latch[7:0] <= dat_w;
      // high byte write reloads a stopped timer
      if (wr_hi) begin
        latch[15:8] <= dat_w;
        if (!cr[cr_start])
          cnt <= {dat_w, latch[7:0]};
      end
      if (wr_cr) begin
        cr          <= dat_w;
        cr[cr_load] <= 1'b0;
        if (dat_w[cr_load])
          cnt <= latch;
      end
    end
  end

  assign cnt_q  = cnt;
  assign cr_q   = cr;
  assign spmode = cr[cra_spmode];

endmodule

/* rtl/cia_timer_b.sv */
`timescale 1ns/1ps

module cia_timer_b import cia_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        eclk,
  input  logic        ta_ovf,
  input  logic [7:0]  dat_w,
  input  logic        wr_lo,
  input  logic        wr_hi,
  input  logic        wr_cr,
  output logic [15:0] cnt_q,
  output logic [7:0]  cr_q,
  output logic        tb_ovf
);

  logic [15:0] latch;
  logic [15:0] cnt;
  logic [7:0]  cr;
  logic        tick;
  logic        count_en;

  // cascade mode counts timer A underflows
  assign tick     = cr[crb_inmode] ? ta_ovf : eclk;
  assign count_en = tick & cr[cr_start];
  assign tb_ovf   = count_en & (cnt == 16'h0000);

  always_ff @(posedge clk) begin
    if (reset) begin
      latch <= 16'hffff;
      cnt   <= 16'hffff;
      cr    <= 8'h00;
    end else begin
      if (tb_ovf) begin
        cnt <= latch;
        if (cr[cr_oneshot])
          cr[cr_start] <= 1'b0;
      end else if (count_en) begin
        cnt <= cnt - 16'd1;
      end
      if (wr_lo)
        latch[7:0] <= dat_w;
      if (wr_hi) begin
        latch[15:8] <= dat_w;
        if (!cr[cr_start])
          cnt <= {dat_w, latch[7:0]};
      end
      // load strobe acts once and is not kept
      if (wr_cr) begin
        cr          <= dat_w;
        cr[cr_load] <= 1'b0;
        if (dat_w[cr_load])
          cnt <= latch;
      end
    end
  end

  assign cnt_q = cnt;
  assign cr_q  = cr;

endmodule

/* rtl/cia_tod.sv */
`timescale 1ns/1ps

module cia_tod (
  input  logic        clk,
  input  logic        reset,
  input  logic        tod_tick,
  input  logic        alarm_sel,
  input  logic [7:0]  dat_w,
  input  logic        wr_lo,
  input  logic        wr_mid,
  input  logic        wr_hi,
  input  logic        rd_lo,
  input  logic        rd_hi,
  output logic [23:0] tod_q,
  output logic        alarm
);

  logic        tick_d;
  logic        tick_rise;
  logic        halt;
  logic        frozen;
  logic        changed;
  logic [23:0] cnt;
  logic [23:0] alm;
  logic [23:0] rd_latch;

  assign tick_rise = tod_tick & ~tick_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      tick_d  <= 1'b0;
      halt    <= 1'b0;
      frozen  <= 1'b0;
      changed <= 1'b0;
      alarm   <= 1'b0;
      cnt     <= 24'h000000;
      alm     <= 24'h000000;
    end else begin
      tick_d  <= tod_tick;
      changed <= 1'b0;
      // compare one cycle behind each count update
      alarm   <= changed & (cnt == alm);
      if (tick_rise && !halt) begin
        cnt     <= cnt + 24'd1;
        changed <= 1'b1;
      end
      if (alarm_sel) begin
        if (wr_lo)
          alm[7:0] <= dat_w;
        if (wr_mid)
          alm[15:8] <= dat_w;
        if (wr_hi)
          alm[23:16] <= dat_w;
      end else begin
        // count stops from high byte write to low byte write
        if (wr_lo) begin
          cnt[7:0] <= dat_w;
          halt     <= 1'b0;
          changed  <= 1'b1;
        end
        if (wr_mid) begin
          cnt[15:8] <= dat_w;
          changed   <= 1'b1;
        end
        if (wr_hi) begin
          cnt[23:16] <= dat_w;
          halt       <= 1'b1;
          changed    <= 1'b1;
        end
      end
      if (rd_hi)
        frozen <= 1'b1;
      else if (rd_lo)
        frozen <= 1'b0;
    end
  end

  // snapshot taken by the first high byte read
  always_ff @(posedge clk) begin
    if (rd_hi && !frozen) begin
      rd_latch <= cnt;
    end
  end

  assign tod_q = frozen ? rd_latch : cnt;

endmodule

/* rtl/cia_int.sv */
`timescale 1ns/1ps

module cia_int import cia_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] dat_w,
  input  logic       wr_icr,
  input  logic       rd_icr,
  input  logic       ta,
  input  logic       tb,
  input  logic       alrm,
  input  logic       sp,
  output logic [7:0] icr_q,
  output logic       irq
);

  logic [icr_src_w-1:0] flags;
  logic [icr_src_w-1:0] mask;
  logic [icr_src_w-1:0] src;
  icr_word_u            wr_word;
  icr_word_u            rd_word;

  always_comb begin
    src           = '0;
    src[icr_ta]   = ta;
    src[icr_tb]   = tb;
    src[icr_alrm] = alrm;
    src[icr_sp]   = sp;
  end

  assign wr_word = dat_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      mask <= '0;
    end else if (wr_icr) begin
      if (wr_word.wr.set_clr)
        mask <= mask | wr_word.wr.mask;
      else
        mask <= mask & ~wr_word.wr.mask;
    end
  end

  // sticky flags, a read clears all but a new event
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (rd_icr) begin
      flags <= src;
    end else begin
      flags <= flags | src;
    end
  end

  assign irq = |(flags & mask);

  always_comb begin
    rd_word          = '0;
    rd_word.rd.ir    = irq;
    rd_word.rd.flags = flags;
  end

  assign icr_q = rd_word;

endmodule

/* rtl/cia_8520.sv */
`timescale 1ns/1ps

module cia_8520 import cia_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  logic [3:0] adr,
  input  logic [7:0] dat_w,
  output logic [7:0] dat_r,
  output logic       ack,
  input  logic [7:0] pa_in,
  input  logic       eclk,
  input  logic       tod_tick,
  input  logic       key_valid,
  input  logic [7:0] key_code,
  output logic [7:0] pa_out,
  output logic [7:0] pb_out,
  output logic       keyack,
  output logic       irq
);

  logic        access;
  logic        wr_en;
  logic        rd_en;
  logic [7:0]  rd_mux;
  logic [7:0]  pra_q;
  logic [7:0]  prb_q;
  logic [7:0]  ddra_q;
  logic [7:0]  ddrb_q;
  logic [7:0]  sdr_q;
  logic [7:0]  icr_q;
  logic [7:0]  cra_q;
  logic [7:0]  crb_q;
  logic [15:0] ta_q;
  logic [15:0] tb_q;
  logic [23:0] tod_q;
  logic        spmode;
  logic        ta_ovf;
  logic        tb_ovf;
  logic        alarm;
  logic        sp_event;

  // one transfer per strobe, held off while ack is up
  assign access = cyc & stb & ~ack;
  assign wr_en  = access & we;
  assign rd_en  = access & ~we;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  always_comb begin
    case (adr)
      addr_pra:     rd_mux = pra_q;
      addr_prb:     rd_mux = prb_q;
      addr_ddra:    rd_mux = ddra_q;
      addr_ddrb:    rd_mux = ddrb_q;
      addr_talo:    rd_mux = ta_q[7:0];
      addr_tahi:    rd_mux = ta_q[15:8];
      addr_tblo:    rd_mux = tb_q[7:0];
      addr_tbhi:    rd_mux = tb_q[15:8];
      addr_tod_lo:  rd_mux = tod_q[7:0];
      addr_tod_mid: rd_mux = tod_q[15:8];
      addr_tod_hi:  rd_mux = tod_q[23:16];
      addr_sdr:     rd_mux = sdr_q;
      addr_icr:     rd_mux = icr_q;
      addr_cra:     rd_mux = cra_q;
      addr_crb:     rd_mux = crb_q;
      default:      rd_mux = 8'h00;
    endcase
  end

  // read data captured with the edge that raises ack
  always_ff @(posedge clk) begin
    if (rd_en) begin
      dat_r <= rd_mux;
    end
  end

  cia_ports_sdr i_cia_ports_sdr (
    .clk       (clk),
    .reset     (reset),
    .dat_w     (dat_w),
    .wr_pra    (wr_en & (adr == addr_pra)),
    .wr_prb    (wr_en & (adr == addr_prb)),
    .wr_ddra   (wr_en & (adr == addr_ddra)),
    .wr_ddrb   (wr_en & (adr == addr_ddrb)),
    .wr_sdr    (wr_en & (adr == addr_sdr)),
    .rd_sdr    (rd_en & (adr == addr_sdr)),
    .spmode    (spmode),
    .ta_ovf    (ta_ovf),
    .key_valid (key_valid),
    .key_code  (key_code),
    .pa_in     (pa_in),
    .pa_out    (pa_out),
    .pb_out    (pb_out),
    .pra_q     (pra_q),
    .prb_q     (prb_q),
    .ddra_q    (ddra_q),
    .ddrb_q    (ddrb_q),
    .sdr_q     (sdr_q),
    .keyack    (keyack),
    .sp_event  (sp_event)
  );

  cia_timer_a i_cia_timer_a (
    .clk    (clk),
    .reset  (reset),
    .eclk   (eclk),
    .dat_w  (dat_w),
    .wr_lo  (wr_en & (adr == addr_talo)),
    .wr_hi  (wr_en & (adr == addr_tahi)),
    .wr_cr  (wr_en & (adr == addr_cra)),
    .cnt_q  (ta_q),
    .cr_q   (cra_q),
    .spmode (spmode),
    .ta_ovf (ta_ovf)
  );

  cia_timer_b i_cia_timer_b (
    .clk    (clk),
    .reset  (reset),
    .eclk   (eclk),
    .ta_ovf (ta_ovf),
    .dat_w  (dat_w),
    .wr_lo  (wr_en & (adr == addr_tblo)),
    .wr_hi  (wr_en & (adr == addr_tbhi)),
    .wr_cr  (wr_en & (adr == addr_crb)),
    .cnt_q  (tb_q),
    .cr_q   (crb_q),
    .tb_ovf (tb_ovf)
  );

  cia_tod i_cia_tod (
    .clk       (clk),
    .reset     (reset),
    .tod_tick  (tod_tick),
    .alarm_sel (crb_q[crb_alarm]),
    .dat_w     (dat_w),
    .wr_lo     (wr_en & (adr == addr_tod_lo)),
    .wr_mid    (wr_en & (adr == addr_tod_mid)),
    .wr_hi     (wr_en & (adr == addr_tod_hi)),
    .rd_lo     (rd_en & (adr == addr_tod_lo)),
    .rd_hi     (rd_en & (adr == addr_tod_hi)),
    .tod_q     (tod_q),
    .alarm     (alarm)
  );

  cia_int i_cia_int (
    .clk    (clk),
    .reset  (reset),
    .dat_w  (dat_w),
    .wr_icr (wr_en & (adr == addr_icr)),
    .rd_icr (rd_en & (adr == addr_icr)),
    .ta     (ta_ovf),
    .tb     (tb_ovf),
    .alrm   (alarm),
    .sp     (sp_event),
    .icr_q  (icr_q),
    .irq    (irq)
  );

endmodule

/* test/cia_props.sv */
`timescale 1ns/1ps

module cia_props import cia_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       cyc,
  input logic       stb,
  input logic       we,
  input logic [3:0] adr,
  input logic [7:0] dat_w,
  input logic       ack,
  input logic       irq
);

  icr_word_u            icr_wr;
  logic [icr_src_w-1:0] mask_seen;

  assign icr_wr = dat_w;

  // mask as written over the bus, one update per strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      mask_seen <= '0;
    end else if (cyc && stb && !ack && we && adr == addr_icr) begin
      if (icr_wr.wr.set_clr)
        mask_seen <= mask_seen | icr_wr.wr.mask;
      else
        mask_seen <= mask_seen & ~icr_wr.wr.mask;
    end
  end

  // ack answers a strobe from the previous cycle
  ack_after_strobe: assert property (
    @(posedge clk) disable iff (reset) ack |-> $past(cyc & stb)
  ) else $error("ack without a preceding cyc and stb");

  ack_one_cycle: assert property (
    @(posedge clk) disable iff (reset) ack |=> !ack
  ) else $error("ack held longer than one cycle");

  irq_low_in_reset: assert property (
    @(posedge clk) (reset && $past(reset)) |-> !irq
  ) else $error("irq high during reset");

  // no source can reach irq with every mask bit off
  irq_needs_mask: assert property (
    @(posedge clk) disable iff (reset) (mask_seen == '0) |-> !irq
  ) else $error("irq high with mask cleared");

endmodule

/* test/tb_cia.sv */
`timescale 1ns/1ps

module tb_cia import cia_pkg::*; ();

  localparam int n_port    = 16;
  localparam int n_sdr     = 16;
  localparam int n_tmr     = 6;
  localparam int n_tod     = 4;
  localparam int n_int     = 12;
  localparam int ack_limit = 16;
  // longest single iteration stays well under 600 clocks
  localparam longint watchdog_ns =
    longint'(n_port + n_sdr + 3 * n_tmr + n_tod + n_int + 4) * 600 * 8;

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [3:0]  adr;
  logic [7:0]  dat_w;
  logic [7:0]  dat_r;
  logic        ack;
  logic [7:0]  pa_in;
  logic        eclk;
  logic        tod_tick;
  logic        key_valid;
  logic [7:0]  key_code;
  logic [7:0]  pa_out;
  logic [7:0]  pb_out;
  logic        keyack;
  logic        irq;
  int          keyacks;
  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          test_errs0;
  string       cur_test;

  // model state
  logic [7:0]  m_pra;
  logic [7:0]  m_prb;
  logic [7:0]  m_ddra;
  logic [7:0]  m_ddrb;
  logic [7:0]  m_sdr;
  logic [3:0]  m_mask;
  logic [23:0] m_tod;
  logic [23:0] m_alm;

  cia_8520 i_cia_8520 (
    .clk       (clk),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack),
    .pa_in     (pa_in),
    .eclk      (eclk),
    .tod_tick  (tod_tick),
    .key_valid (key_valid),
    .key_code  (key_code),
    .pa_out    (pa_out),
    .pb_out    (pb_out),
    .keyack    (keyack),
    .irq       (irq)
  );

  bind cia_8520 cia_props i_cia_props (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .ack   (ack),
    .irq   (irq)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("run did not finish within %0d ns and was stopped", watchdog_ns);
    $display("Test FAILED");
    $finish;
  end

  // keyack pulses since reset
  always @(posedge clk) begin
    if (reset)
      keyacks <= 0;
    else if (keyack)
      keyacks <= keyacks + 1;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[0];
      lfsr = lfsr >> 1;
      if (fb)
        lfsr = lfsr ^ 32'h8020_0003;
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic icr_word_u expect_icr(input logic [3:0] fl);
    icr_word_u w;
    w          = '0;
    w.rd.flags = fl;
    w.rd.ir    = |(fl & m_mask);
    return w;
  endfunction

  task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s expected %b actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_tod(input string what, input logic [23:0] exp, input logic [23:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic bus_xfer(input logic wr, input logic [3:0] a, input logic [7:0] d,
                          output logic [7:0] q);
    int n;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!ack && n < ack_limit);
    if (!ack) begin
      errors++;
      $display("bus transfer to address %h was never acknowledged", a);
    end
    q = dat_r;
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic bus_write(input logic [3:0] a, input logic [7:0] d);
    logic [7:0] q;
    bus_xfer(1'b1, a, d, q);
  endtask

  task automatic bus_read(input logic [3:0] a, output logic [7:0] q);
    bus_xfer(1'b0, a, 8'h00, q);
  endtask

  task automatic expect_read(input string what, input logic [3:0] a, input logic [7:0] exp);
    logic [7:0] q;
    bus_read(a, q);
    check_byte(what, exp, q);
  endtask

  task automatic read_tod(output logic [23:0] t);
    bus_read(addr_tod_hi, t[23:16]);
    bus_read(addr_tod_mid, t[15:8]);
    bus_read(addr_tod_lo, t[7:0]);
  endtask

  task automatic write_tod(input logic [23:0] t);
    bus_write(addr_tod_hi, t[23:16]);
    bus_write(addr_tod_mid, t[15:8]);
    bus_write(addr_tod_lo, t[7:0]);
  endtask

  task automatic eclk_pulses(input int n);
    repeat (n) begin
      @(posedge clk);
      eclk <= 1'b1;
      @(posedge clk);
      eclk <= 1'b0;
    end
  endtask

  task automatic tod_ticks(input int n);
    repeat (n) begin
      @(posedge clk);
      tod_tick <= 1'b1;
      @(posedge clk);
      tod_tick <= 1'b0;
    end
  endtask

  task automatic key_event(input logic [7:0] k);
    @(posedge clk);
    key_valid <= 1'b1;
    key_code  <= k;
    @(posedge clk);
    key_valid <= 1'b0;
    m_sdr = ~{k[6:0], k[7]};
  endtask

  task automatic clear_icr();
    logic [7:0] q;
    bus_read(addr_icr, q);
  endtask

  task automatic start_test(input string name);
    cur_test   = name;
    test_errs0 = errors;
  endtask

  task automatic end_test();
    if (errors == test_errs0)
      $display("%-8s passed", cur_test);
    else
      $display("%-8s failed with %0d errors", cur_test, errors - test_errs0);
  endtask

  initial begin
    logic [7:0]  v;
    logic [7:0]  pin;
    logic [1:0]  sel;
    logic [3:0]  ev;
    logic [23:0] t;
    int          la;
    int          lb;
    int          k;
    int          n_ack;
    lfsr      = 32'hef49_8473;
    errors    = 0;
    checks    = 0;
    reset     = 1'b1;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = 4'h0;
    dat_w     = 8'h00;
    pa_in     = 8'h00;
    eclk      = 1'b0;
    tod_tick  = 1'b0;
    key_valid = 1'b0;
    key_code  = 8'h00;
    m_pra = 8'h00;
    m_prb = 8'h00;
    m_ddra = 8'h00;
    m_ddrb = 8'h00;
    m_sdr = 8'h00;
    m_mask = 4'h0;
    m_tod = 24'h0;
    m_alm = 24'h0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    start_test("ports");
    for (int i = 0; i < n_port; i++) begin
      sel = 2'(rand_bits(2));
      v   = 8'(rand_bits(8));
      case (sel)
        2'd0: begin
          bus_write(addr_pra, v);
          m_pra = v;
        end
        2'd1: begin
          bus_write(addr_prb, v);
          m_prb = v;
        end
        2'd2: begin
          bus_write(addr_ddra, v);
          m_ddra = v;
        end
        default: begin
          bus_write(addr_ddrb, v);
          m_ddrb = v;
        end
      endcase
      #1;
      check_byte("pa_out", ~m_ddra | m_pra, pa_out);
      check_byte("pb_out", ~m_ddrb | m_prb, pb_out);
      pin = 8'(rand_bits(8));
      @(posedge clk);
      pa_in <= pin;
      expect_read("pra", addr_pra, (m_ddra & m_pra) | (~m_ddra & pin));
      expect_read("prb", addr_prb, ~m_ddrb | m_prb);
      expect_read("ddra", addr_ddra, m_ddra);
      expect_read("ddrb", addr_ddrb, m_ddrb);
    end
    expect_read("unused", 4'hb, 8'h00);
    end_test();

    start_test("sdr");
    for (int i = 0; i < n_sdr; i++) begin
      v = 8'(rand_bits(8));
      if (rand_bits(1)) begin
        key_event(v);
      end else begin
        bus_write(addr_sdr, v);
        m_sdr = v;
      end
      n_ack = keyacks;
      expect_read("sdr", addr_sdr, m_sdr);
      check_bit("keyack", 1'b1, keyacks == n_ack + 1);
    end
    end_test();

    start_test("timers");
    for (int i = 0; i < n_tmr; i++) begin
      la = rand_bits(6);
      v  = {4'b0000, 1'(rand_bits(1)), 3'b001};
      bus_write(addr_talo, la[7:0]);
      bus_write(addr_tahi, 8'h00);
      expect_read("talo", addr_talo, la[7:0]);
      clear_icr();
      bus_write(addr_cra, v);
      eclk_pulses(la);
      expect_read("icr before underflow", addr_icr, expect_icr(4'b0000));
      eclk_pulses(1);
      expect_read("icr at underflow", addr_icr, expect_icr(4'b0001));
      expect_read("cra", addr_cra, v[cr_oneshot] ? 8'h08 : v);
      bus_write(addr_cra, 8'h00);
    end
    for (int i = 0; i < n_tmr; i++) begin
      la = rand_bits(2);
      lb = rand_bits(2);
      bus_write(addr_talo, la[7:0]);
      bus_write(addr_tahi, 8'h00);
      bus_write(addr_tblo, lb[7:0]);
      bus_write(addr_tbhi, 8'h00);
      expect_read("tblo", addr_tblo, lb[7:0]);
      clear_icr();
      bus_write(addr_crb, 8'h21);
      bus_write(addr_cra, 8'h01);
      eclk_pulses((la + 1) * (lb + 1) - 1);
      expect_read("cascade early", addr_icr, expect_icr({3'b000, lb != 0}));
      eclk_pulses(1);
      expect_read("cascade", addr_icr, expect_icr(4'b0011));
      bus_write(addr_cra, 8'h00);
      bus_write(addr_crb, 8'h00);
    end
    end_test();

    start_test("tod");
    for (int i = 0; i < n_tod; i++) begin
      k = rand_bits(5);
      write_tod(24'h0);
      tod_ticks(k);
      m_tod = 24'(k);
      read_tod(t);
      check_tod("count", m_tod, t);
      // high byte read freezes the reported value
      bus_read(addr_tod_hi, t[23:16]);
      k = rand_bits(3) + 1;
      tod_ticks(k);
      bus_read(addr_tod_mid, t[15:8]);
      bus_read(addr_tod_lo, t[7:0]);
      check_tod("frozen", m_tod, t);
      m_tod = m_tod + 24'(k);
      read_tod(t);
      check_tod("released", m_tod, t);
    end
    k = rand_bits(3) + 1;
    m_alm = m_tod + 24'(k);
    bus_write(addr_crb, 8'h80);
    write_tod(m_alm);
    bus_write(addr_crb, 8'h00);
    clear_icr();
    tod_ticks(k - 1);
    expect_read("alarm early", addr_icr, expect_icr(4'b0000));
    tod_ticks(1);
    repeat (2) @(posedge clk);
    expect_read("alarm", addr_icr, expect_icr(4'b0100));
    end_test();

    start_test("irq");
    bus_write(addr_talo, 8'h00);
    bus_write(addr_tahi, 8'h00);
    bus_write(addr_tblo, 8'h00);
    bus_write(addr_tbhi, 8'h00);
    for (int i = 0; i < n_int; i++) begin
      clear_icr();
      repeat (1 + rand_bits(1)) begin
        v = {1'(rand_bits(1)), 3'b000, 4'(rand_bits(4))};
        bus_write(addr_icr, v);
        if (v[7])
          m_mask = m_mask | v[3:0];
        else
          m_mask = m_mask & ~v[3:0];
      end
      ev = 4'(rand_bits(4));
      if (ev[icr_ta]) begin
        bus_write(addr_cra, 8'h09);
        eclk_pulses(1);
      end
      if (ev[icr_tb]) begin
        bus_write(addr_crb, 8'h09);
        eclk_pulses(1);
      end
      if (ev[icr_alrm])
        write_tod(m_alm);
      if (ev[icr_sp])
        key_event(8'(rand_bits(8)));
      repeat (2) @(posedge clk);
      #1;
      check_bit("irq", |(ev & m_mask), irq);
      expect_read("icr", addr_icr, expect_icr(ev));
      expect_read("icr cleared", addr_icr, expect_icr(4'b0000));
    end
    bus_write(addr_icr, 8'h0f);
    m_mask = 4'h0;
    end_test();

    start_test("serial");
    for (int i = 0; i < 4; i++) begin
      la = rand_bits(2);
      bus_write(addr_talo, la[7:0]);
      bus_write(addr_tahi, 8'h00);
      bus_write(addr_cra, 8'h41);
      clear_icr();
      v = 8'(rand_bits(8));
      bus_write(addr_sdr, v);
      m_sdr = v;
      eclk_pulses(16 * (la + 1) - 1);
      expect_read("before last bit", addr_icr, expect_icr(4'b0001));
      eclk_pulses(1);
      expect_read("last bit", addr_icr, expect_icr(4'b1001));
      bus_write(addr_cra, 8'h00);
    end
    end_test();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/cia_pkg.sv
rtl/cia_ports_sdr.sv
rtl/cia_timer_a.sv
rtl/cia_timer_b.sv
rtl/cia_tod.sv
rtl/cia_int.sv
rtl/cia_8520.sv
test/cia_props.sv
test/tb_cia.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cia
FLIST     ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD) -o sim_$(TOP)
	-./$(BUILD)/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
